/* matmul_kernel.f */
rtl/matmul_pkg.sv
rtl/kernel_control.sv
rtl/weight_loader.sv
rtl/mac_stage.sv
rtl/mac_pipeline.sv
rtl/result_drain.sv
rtl/matmul_kernel.sv
verif/matmul_tb.sv

/* rtl/kernel_control.sv */
/*
 * Start-edge detection, busy state and the ap_idle, ap_done, ap_ready outputs
 */
`default_nettype none
`timescale 1ns/1ps

module kernel_control import matmul_pkg::*; (
  input  wire  ap_clk,
  input  wire  areset,
  input  wire  ap_start,
  input  wire  job_complete,
  output logic start_pulse,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready
);

  ctrl_state_e state;
  logic        ap_start_r;

  // Rising edge of ap_start, ignored while a job is running
  assign start_pulse = ap_start & ~ap_start_r & (state == CTRL_IDLE);

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start_r <= 1'b0;
    end else begin
      ap_start_r <= ap_start;
    end
  end

  // Done pulse lands on the same edge that returns the FSM to idle
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state   <= CTRL_IDLE;
      ap_done <= 1'b0;
    end else begin
      ap_done <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          if (start_pulse) begin
            state <= CTRL_BUSY;
          end
        end
        CTRL_BUSY: begin
          if (job_complete) begin
            state   <= CTRL_IDLE;
            ap_done <= 1'b1;
          end
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

  assign ap_idle  = (state == CTRL_IDLE);
  assign ap_ready = ap_done;

endmodule : kernel_control

`default_nettype wire

/* rtl/mac_pipeline.sv */
/*
 * Execute stage: ARRAY_N chained MAC stages sharing one advance,
 * with several input rows in flight
 */
`default_nettype none
`timescale 1ns/1ps

module mac_pipeline import matmul_pkg::*; #(
  parameter int ARRAY_N = DEFAULT_ARRAY_N
) (
  input  wire                                    ap_clk,
  input  wire                                    areset,
  input  wire                                    advance,
  input  wire  elem_t [ARRAY_N-1:0][ARRAY_N-1:0] weight_bank,
  input  wire                                    in_valid,
  input  wire  elem_t [ARRAY_N-1:0]              in_data,
  output logic                                   res_valid,
  output acc_t  [ARRAY_N-1:0]                    res_data
);

  // Entry k feeds stage k, entry ARRAY_N leaves the last stage
  elem_t [ARRAY_N-1:0] x_chain    [ARRAY_N+1];
  acc_t  [ARRAY_N-1:0] psum_chain [ARRAY_N+1];
  logic  [ARRAY_N:0]   valid_chain;

  // Stage 0 starts from zero sums
  assign x_chain[0]     = in_data;
  assign psum_chain[0]  = '0;
  assign valid_chain[0] = in_valid;

  //////////////////////////////////////////////////////////////////////
  // Stage chain, stage i holds weight row i
  //////////////////////////////////////////////////////////////////////
  for (genvar i = 0; i < ARRAY_N; i++) begin : g_stage
    mac_stage #(
      .ARRAY_N ( ARRAY_N ),
      .STAGE   ( i       )
    ) stage_inst (
      .ap_clk     ( ap_clk             ),
      .areset     ( areset             ),
      .advance    ( advance            ),
      .weight_row ( weight_bank[i]     ),
      .x_in       ( x_chain[i]         ),
      .psum_in    ( psum_chain[i]      ),
      .valid_in   ( valid_chain[i]     ),
      .x_out      ( x_chain[i+1]       ),
      .psum_out   ( psum_chain[i+1]    ),
      .valid_out  ( valid_chain[i+1]   )
    );
  end

  // Finished sums after the last stage
  assign res_valid = valid_chain[ARRAY_N];
  assign res_data  = psum_chain[ARRAY_N];

endmodule : mac_pipeline

`default_nettype wire

/* rtl/mac_stage.sv */
/*
 * One MAC pipeline stage: adds x[STAGE] times weight row STAGE
 * to the partial sums and passes the input vector on
 */
`default_nettype none
`timescale 1ns/1ps

module mac_stage import matmul_pkg::*; #(
  parameter int ARRAY_N = DEFAULT_ARRAY_N,
  parameter int STAGE   = 0
) (
  input  wire                       ap_clk,
  input  wire                       areset,
  input  wire                       advance,
  input  wire  elem_t [ARRAY_N-1:0] weight_row,
  input  wire  elem_t [ARRAY_N-1:0] x_in,
  input  wire  acc_t  [ARRAY_N-1:0] psum_in,
  input  wire                       valid_in,
  output elem_t [ARRAY_N-1:0]       x_out,
  output acc_t  [ARRAY_N-1:0]       psum_out,
  output logic                      valid_out
);

  acc_t [ARRAY_N-1:0] psum_next;
  acc_t               x_elem;

  // Element of x owned by this stage, widened to the lane width
  assign x_elem = acc_t'(x_in[STAGE]);

  // One multiply per output column, wrapping at ACC_W bits
  always_comb begin
    for (int j = 0; j < ARRAY_N; j++) begin
      psum_next[j] = psum_in[j] + x_elem * acc_t'(weight_row[j]);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      valid_out <= 1'b0;
    end else if (advance) begin
      valid_out <= valid_in;
    end
  end

  // Payload only moves with a valid row
  always_ff @(posedge ap_clk) begin
    if (advance && valid_in) begin
      x_out    <= x_in;
      psum_out <= psum_next;
    end
  end

endmodule : mac_stage

`default_nettype wire

/* rtl/matmul_kernel.sv */
/*
 * Weight-stationary matrix-multiply kernel top level:
 * control, decode, execute and result stages
 */
`default_nettype none
`timescale 1ns/1ps

module matmul_kernel import matmul_pkg::*; #(
  parameter int ARRAY_N  = DEFAULT_ARRAY_N,
  parameter int NUM_ROWS = DEFAULT_NUM_ROWS
) (
  input  wire                       ap_clk,
  input  wire                       areset,
  // Control
  input  wire                       ap_start,
  output logic                      ap_idle,
  output logic                      ap_done,
  output logic                      ap_ready,
  output logic                      weights_loaded,
  // Weight row stream
  input  wire                       weight_tvalid,
  output logic                      weight_tready,
  input  wire  [ARRAY_N*ELEM_W-1:0] weight_tdata,
  // Input row stream
  input  wire                       input_tvalid,
  output logic                      input_tready,
  input  wire  [ARRAY_N*ELEM_W-1:0] input_tdata,
  // Result stream
  output logic                      output_tvalid,
  input  wire                       output_tready,
  output logic [ARRAY_N*ACC_W-1:0]  output_tdata
);

  logic                             start_pulse;
  logic                             job_complete;
  logic                             advance;
  elem_t [ARRAY_N-1:0][ARRAY_N-1:0] weight_bank;
  logic                             in_valid;
  elem_t [ARRAY_N-1:0]              in_data;
  logic                             res_valid;
  acc_t  [ARRAY_N-1:0]              res_data;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  kernel_control control_inst (
    .ap_clk       ( ap_clk       ),
    .areset       ( areset       ),
    .ap_start     ( ap_start     ),
    .job_complete ( job_complete ),
    .start_pulse  ( start_pulse  ),
    .ap_idle      ( ap_idle      ),
    .ap_done      ( ap_done      ),
    .ap_ready     ( ap_ready     )
  );

  //////////////////////////////////////////////////////////////////////
  // Decode, execute, result
  //////////////////////////////////////////////////////////////////////
  weight_loader #(
    .ARRAY_N  ( ARRAY_N  ),
    .NUM_ROWS ( NUM_ROWS )
  ) loader_inst (
    .ap_clk         ( ap_clk         ),
    .areset         ( areset         ),
    .start_pulse    ( start_pulse    ),
    .advance        ( advance        ),
    .weight_tvalid  ( weight_tvalid  ),
    .weight_tdata   ( weight_tdata   ),
    .input_tvalid   ( input_tvalid   ),
    .input_tdata    ( input_tdata    ),
    .weight_tready  ( weight_tready  ),
    .input_tready   ( input_tready   ),
    .weights_loaded ( weights_loaded ),
    .weight_bank    ( weight_bank    ),
    .in_valid       ( in_valid       ),
    .in_data        ( in_data        )
  );

  mac_pipeline #(
    .ARRAY_N ( ARRAY_N )
  ) pipeline_inst (
    .ap_clk      ( ap_clk      ),
    .areset      ( areset      ),
    .advance     ( advance     ),
    .weight_bank ( weight_bank ),
    .in_valid    ( in_valid    ),
    .in_data     ( in_data     ),
    .res_valid   ( res_valid   ),
    .res_data    ( res_data    )
  );

  result_drain #(
    .ARRAY_N  ( ARRAY_N  ),
    .NUM_ROWS ( NUM_ROWS )
  ) drain_inst (
    .ap_clk        ( ap_clk        ),
    .areset        ( areset        ),
    .res_valid     ( res_valid     ),
    .res_data      ( res_data      ),
    .output_tready ( output_tready ),
    .output_tvalid ( output_tvalid ),
    .output_tdata  ( output_tdata  ),
    .advance       ( advance       ),
    .job_complete  ( job_complete  )
  );

endmodule : matmul_kernel

`default_nettype wire

/* rtl/matmul_pkg.sv */
/*
 * Shared widths, element and accumulator types, default sizes
 * and the FSM state enums of the matrix-multiply kernel
 */
`default_nettype none

package matmul_pkg;

  // Element and result lane widths
  localparam int ELEM_W = 16;
  localparam int ACC_W  = 32;

  typedef logic [ELEM_W-1:0] elem_t;
  typedef logic [ACC_W-1:0]  acc_t;

  // Default array size and rows per job
  localparam int DEFAULT_ARRAY_N  = 4;
  localparam int DEFAULT_NUM_ROWS = 8;

  typedef enum logic {
    CTRL_IDLE,
    CTRL_BUSY
  } ctrl_state_e;

  typedef enum logic [1:0] {
    LOAD_WAIT,
    LOAD_WEIGHTS,
    LOAD_INPUTS
  } load_state_e;

endpackage : matmul_pkg

`default_nettype wire

/* rtl/result_drain.sv */
/*
 * Result stage: output register and lane packing toward the output stream,
 * pipeline advance, word counting and job completion
 */
`default_nettype none
`timescale 1ns/1ps

module result_drain import matmul_pkg::*; #(
  parameter int ARRAY_N  = DEFAULT_ARRAY_N,
  parameter int NUM_ROWS = DEFAULT_NUM_ROWS
) (
  input  wire                      ap_clk,
  input  wire                      areset,
  input  wire                      res_valid,
  input  wire  acc_t [ARRAY_N-1:0] res_data,
  input  wire                      output_tready,
  output logic                     output_tvalid,
  output logic [ARRAY_N*ACC_W-1:0] output_tdata,
  output logic                     advance,
  output logic                     job_complete
);

  localparam int CNT_W = $clog2(NUM_ROWS + 1);

  acc_t [ARRAY_N-1:0] out_data;
  logic [CNT_W-1:0]   word_cnt;
  logic               out_accept;

  // Whole pipeline freezes while a held word waits
  assign advance      = ~output_tvalid | output_tready;
  assign out_accept   = output_tvalid & output_tready;
  assign job_complete = out_accept & (word_cnt == CNT_W'(NUM_ROWS - 1));

  always_comb begin
    for (int j = 0; j < ARRAY_N; j++) begin
      output_tdata[j*ACC_W +: ACC_W] = out_data[j];
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      output_tvalid <= 1'b0;
    end else if (advance) begin
      output_tvalid <= res_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (advance && res_valid) begin
      out_data <= res_data;
    end
  end

  // Accepted words per job, wraps for the next job
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      word_cnt <= '0;
    end else if (job_complete) begin
      word_cnt <= '0;
    end else if (out_accept) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

endmodule : result_drain

`default_nettype wire

/* rtl/weight_loader.sv */
/*
 * Decode stage: captures weight rows into the bank, then admits,
 * counts and forwards input rows to the MAC pipeline
 */
`default_nettype none
`timescale 1ns/1ps

module weight_loader import matmul_pkg::*; #(
  parameter int ARRAY_N  = DEFAULT_ARRAY_N,
  parameter int NUM_ROWS = DEFAULT_NUM_ROWS
) (
  input  wire                               ap_clk,
  input  wire                               areset,
  input  wire                               start_pulse,
  input  wire                               advance,
  input  wire                               weight_tvalid,
  input  wire  [ARRAY_N*ELEM_W-1:0]         weight_tdata,
  input  wire                               input_tvalid,
  input  wire  [ARRAY_N*ELEM_W-1:0]         input_tdata,
  output logic                              weight_tready,
  output logic                              input_tready,
  output logic                              weights_loaded,
  output elem_t [ARRAY_N-1:0][ARRAY_N-1:0]  weight_bank,
  output logic                              in_valid,
  output elem_t [ARRAY_N-1:0]               in_data
);

  localparam int W_CNT_W = $clog2(ARRAY_N + 1);
  localparam int R_CNT_W = $clog2(NUM_ROWS + 1);

  load_state_e         state;
  logic [W_CNT_W-1:0]  w_row_cnt;
  logic [R_CNT_W-1:0]  in_row_cnt;
  elem_t [ARRAY_N-1:0] w_lanes;
  elem_t [ARRAY_N-1:0] x_lanes;
  logic                w_accept;
  logic                x_accept;

  // Lane j sits at bit j*ELEM_W upward on both streams
  always_comb begin
    for (int j = 0; j < ARRAY_N; j++) begin
      w_lanes[j] = weight_tdata[j*ELEM_W +: ELEM_W];
      x_lanes[j] = input_tdata[j*ELEM_W +: ELEM_W];
    end
  end

  // Stream steering by phase
  assign weight_tready = (state == LOAD_WEIGHTS);
  assign input_tready  = (state == LOAD_INPUTS) & advance;
  assign w_accept      = weight_tvalid & weight_tready;
  assign x_accept      = input_tvalid & input_tready;

  //////////////////////////////////////////////////////////////////////
  // Phase FSM and row counters
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state          <= LOAD_WAIT;
      w_row_cnt      <= '0;
      in_row_cnt     <= '0;
      weights_loaded <= 1'b0;
    end else if (start_pulse) begin
      state          <= LOAD_WEIGHTS;
      w_row_cnt      <= '0;
      in_row_cnt     <= '0;
      weights_loaded <= 1'b0;
    end else begin
      case (state)
        LOAD_WEIGHTS: begin
          if (w_accept) begin
            if (w_row_cnt == W_CNT_W'(ARRAY_N - 1)) begin
              state          <= LOAD_INPUTS;
              w_row_cnt      <= '0;
              weights_loaded <= 1'b1;
            end else begin
              w_row_cnt <= w_row_cnt + 1'b1;
            end
          end
        end
        LOAD_INPUTS: begin
          if (x_accept) begin
            if (in_row_cnt == R_CNT_W'(NUM_ROWS - 1)) begin
              state      <= LOAD_WAIT;
              in_row_cnt <= '0;
            end else begin
              in_row_cnt <= in_row_cnt + 1'b1;
            end
          end
        end
        default: state <= LOAD_WAIT;
      endcase
    end
  end

  // Weight row i lands in bank row i
  always_ff @(posedge ap_clk) begin
    if (w_accept) begin
      weight_bank[w_row_cnt] <= w_lanes;
    end
  end

  // Input register in front of stage 0, moves only with the pipeline
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      in_valid <= 1'b0;
    end else if (advance) begin
      in_valid <= x_accept;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (advance && x_accept) begin
      in_data <= x_lanes;
    end
  end

endmodule : weight_loader

`default_nettype wire

/* verif/matmul_tb.sv */
/*
 * Testbench for the matrix-multiply kernel: clock, reset, LFSR stimulus,
 * reference model with expected-row queue, check task, timeout and verdict
 */
`default_nettype none
`timescale 1ns/1ps

module matmul_tb
  import matmul_pkg::*;
();

  localparam int N       = DEFAULT_ARRAY_N;
  localparam int ROWS    = DEFAULT_NUM_ROWS;
  localparam int JOBS    = 3;
  localparam int DW      = N * ACC_W;
  localparam int TIMEOUT = JOBS * (N + ROWS) * 8 + 200;

  logic                ap_clk;
  logic                areset;
  logic                ap_start;
  logic                ap_idle;
  logic                ap_done;
  logic                ap_ready;
  logic                weights_loaded;
  logic                weight_tvalid;
  logic                weight_tready;
  logic [N*ELEM_W-1:0] weight_tdata;
  logic                input_tvalid;
  logic                input_tready;
  logic [N*ELEM_W-1:0] input_tdata;
  logic                output_tvalid;
  logic                output_tready;
  logic [DW-1:0]       output_tdata;

  // Model state
  logic [31:0]   lfsr_state;
  elem_t         w_model [N][N];
  logic [DW-1:0] exp_q [$];
  int            w_acc;
  int            x_acc;
  int            y_acc;
  logic          w_pend;
  logic          x_pend;
  logic          out_held;
  logic [DW-1:0] held_data;
  int            cycle_cnt = 0;

  matmul_kernel matmul_kernel_inst (
    .ap_clk         ( ap_clk         ),
    .areset         ( areset         ),
    .ap_start       ( ap_start       ),
    .ap_idle        ( ap_idle        ),
    .ap_done        ( ap_done        ),
    .ap_ready       ( ap_ready       ),
    .weights_loaded ( weights_loaded ),
    .weight_tvalid  ( weight_tvalid  ),
    .weight_tready  ( weight_tready  ),
    .weight_tdata   ( weight_tdata   ),
    .input_tvalid   ( input_tvalid   ),
    .input_tready   ( input_tready   ),
    .input_tdata    ( input_tdata    ),
    .output_tvalid  ( output_tvalid  ),
    .output_tready  ( output_tready  ),
    .output_tdata   ( output_tdata   )
  );

  always #2 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  task automatic rand_row(output logic [N*ELEM_W-1:0] row);
    logic [31:0] r;
    for (int j = 0; j < N; j++) begin
      take_bits(ELEM_W, r);
      row[j*ELEM_W +: ELEM_W] = r[ELEM_W-1:0];
    end
  endtask

  // High three times out of four
  task automatic chance(output logic hit);
    logic [31:0] r;
    take_bits(2, r);
    hit = (r[1:0] != 2'b00);
  endtask

  // Lane j sums x[i] * W[i][j] over i modulo 2**ACC_W
  function automatic logic [DW-1:0] model_row(input logic [N*ELEM_W-1:0] x);
    logic [DW-1:0]    y;
    logic [ACC_W-1:0] acc;
    for (int j = 0; j < N; j++) begin
      acc = '0;
      for (int i = 0; i < N; i++) begin
        acc = acc + ACC_W'(x[i*ELEM_W +: ELEM_W]) * ACC_W'(w_model[i][j]);
      end
      y[j*ACC_W +: ACC_W] = acc;
    end
    return y;
  endfunction

  task automatic check(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                       input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Job sequences
  //////////////////////////////////////////////////////////////////////

  // Idle kernel with all streams offered and nothing taken
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge ap_clk);
      weight_tvalid = 1'b1;
      input_tvalid  = 1'b1;
      output_tready = 1'b1;
      #1;
      check(ap_idle, 1'b1, "ap_idle low between jobs");
      check(ap_done, 1'b0, "ap_done outside job end");
      check(weight_tready, 1'b0, "weight_tready high while idle");
      check(input_tready, 1'b0, "input_tready high while idle");
      check(output_tvalid, 1'b0, "output_tvalid high while idle");
    end
  endtask

  task automatic run_job(input logic hold_start);
    logic                hit;
    logic                done_seen;
    logic [N*ELEM_W-1:0] row;
    w_acc     = 0;
    x_acc     = 0;
    y_acc     = 0;
    w_pend    = 1'b0;
    x_pend    = 1'b0;
    out_held  = 1'b0;
    done_seen = 1'b0;
    exp_q.delete();
    @(negedge ap_clk);
    ap_start      = 1'b0;
    weight_tvalid = 1'b0;
    input_tvalid  = 1'b0;
    @(negedge ap_clk);
    ap_start = 1'b1;
    #1;
    check(ap_idle, 1'b1, "ap_idle fell before the start edge was taken");
    while (!done_seen) begin
      @(negedge ap_clk);
      if (!hold_start) begin
        ap_start = 1'b0;
      end
      if (!w_pend && w_acc < N) begin
        chance(hit);
        if (hit) begin
          rand_row(row);
          weight_tdata = row;
          for (int j = 0; j < N; j++) begin
            w_model[w_acc][j] = row[j*ELEM_W +: ELEM_W];
          end
          w_pend = 1'b1;
        end
      end
      weight_tvalid = w_pend;
      if (!x_pend && x_acc < ROWS) begin
        chance(hit);
        if (hit) begin
          rand_row(row);
          input_tdata = row;
          x_pend      = 1'b1;
        end
      end
      input_tvalid = x_pend;
      chance(hit);
      output_tready = hit;
      #1;
      check(weight_tready && w_acc == N, 1'b0, "weight_tready after the last weight row");
      check(weights_loaded, w_acc == N, "weights_loaded timing");
      check(input_tready && !weights_loaded, 1'b0, "input_tready before weights_loaded");
      check(input_tready && x_acc == ROWS, 1'b0, "input_tready after the last input row");
      check(ap_done, y_acc == ROWS, "ap_done timing");
      check(ap_ready, ap_done, "ap_ready differs from ap_done");
      check(ap_idle, y_acc == ROWS, "ap_idle level during the job");
      if (out_held) begin
        check(output_tvalid, 1'b1, "output_tvalid dropped under back-pressure");
        check(output_tdata, held_data, "output_tdata changed under back-pressure");
      end
      // Transfers that happen at the coming rising edge
      if (weight_tvalid && weight_tready) begin
        w_acc++;
        w_pend = 1'b0;
      end
      if (input_tvalid && input_tready) begin
        exp_q.push_back(model_row(input_tdata));
        x_acc++;
        x_pend = 1'b0;
      end
      if (output_tvalid && output_tready) begin
        check(exp_q.size() != 0, 1'b1, "result word without a matching input row");
        check(output_tdata, exp_q.pop_front(), "result row mismatch");
        y_acc++;
      end
      out_held  = output_tvalid && !output_tready;
      held_data = output_tdata;
      done_seen = ap_done;
    end
  endtask

  initial begin
    ap_clk        = 1'b0;
    areset        = 1'b1;
    ap_start      = 1'b0;
    weight_tvalid = 1'b0;
    weight_tdata  = '0;
    input_tvalid  = 1'b0;
    input_tdata   = '0;
    output_tready = 1'b0;
    lfsr_state    = 32'd66292;
    repeat (4) @(negedge ap_clk);
    areset = 1'b0;
    #1;
    check(ap_idle, 1'b1, "ap_idle after reset");
    check(ap_done, 1'b0, "ap_done after reset");
    check(output_tvalid, 1'b0, "output_tvalid after reset");
    check(weight_tready, 1'b0, "weight_tready after reset");
    check(input_tready, 1'b0, "input_tready after reset");
    check(weights_loaded, 1'b0, "weights_loaded after reset");
    idle_cycles(2);
    // One job with a short start pulse and two with ap_start held through the job
    run_job(1'b0);
    idle_cycles(3);
    run_job(1'b1);
    idle_cycles(3);
    run_job(1'b1);
    idle_cycles(3);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : matmul_tb

`default_nettype wire
